//--- vga_pkg.sv
/*
 * vga_pkg
 * shared display timing, text window geometry, colours,
 * the video sample struct and the register map of the text overlay
 */

package vga_pkg;

  // 640x480 at 60 Hz, 25 MHz pixel clock
  localparam logic [10:0] h_visible    = 11'd640;
  localparam logic [10:0] h_sync_start = 11'd656;
  localparam logic [10:0] h_sync_end   = 11'd752;
  localparam logic [10:0] h_total      = 11'd800;

  localparam logic [10:0] v_visible    = 11'd480;
  localparam logic [10:0] v_sync_start = 11'd490;
  localparam logic [10:0] v_sync_end   = 11'd492;
  localparam logic [10:0] v_total      = 11'd525;

  // text window, 16x16 cells of 8x16 pixels
  localparam logic [10:0] rect_x = 11'd250;
  localparam logic [10:0] rect_y = 11'd200;
  localparam logic [10:0] rect_w = 11'd128;
  localparam logic [10:0] rect_h = 11'd256;

  localparam int text_cols = 16;
  localparam int text_rows = 16;
  localparam int char_w    = 8;
  localparam int char_h    = 16;

  localparam logic [11:0] rgb_black      = 12'h000;
  localparam logic [11:0] rgb_white      = 12'hfff;
  localparam logic [11:0] text_color_rst = 12'h8f8;

  // one video sample as it moves down the pipeline
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    logic [11:0] rgb;
  } vga_bus_t;

  // apb address regions
  typedef enum logic [0:0] {
    text_cells,  // 0x000..0x3fc, one code per word
    ctrl         // colour and enable
  } apb_reg_e;

  localparam logic [11:0] ctrl_addr = 12'h400;

endpackage

//--- delay.sv
/*
 * delay
 * fixed latency shift register, clk_del stages of width bits,
 * all stages clear on reset
 */

`timescale 1ns/10ps

module delay #(
  parameter int width   = 8,
  parameter int clk_del = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout
);

  logic [width-1:0] stage [clk_del];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < clk_del; i++) stage[i] <= '0;
    end else begin
      stage[0] <= din;
      for (int i = 1; i < clk_del; i++) stage[i] <= stage[i-1];
    end
  end

  assign dout = stage[clk_del-1];

endmodule

//--- vga_timing.sv
/*
 * vga_timing
 * 640x480 counter based timing generator, all outputs registered,
 * sync and blank decoded from the next count so they line up with it
 */

`timescale 1ns/10ps

module vga_timing import vga_pkg::*; (
  input  logic     pclk,
  input  logic     rst,
  output vga_bus_t vga_out
);

  logic [10:0] h_nxt;
  logic [10:0] v_nxt;

  // next position, line advances at end of each row
  always_comb begin
    h_nxt = vga_out.hcount + 11'd1;
    v_nxt = vga_out.vcount;
    if (vga_out.hcount == h_total - 11'd1) begin
      h_nxt = 11'd0;
      if (vga_out.vcount == v_total - 11'd1) begin
        v_nxt = 11'd0;
      end else begin
        v_nxt = vga_out.vcount + 11'd1;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out <= '0;  // restart at (0,0)
    end else begin
      vga_out.hcount <= h_nxt;
      vga_out.vcount <= v_nxt;
      vga_out.hsync  <= (h_nxt >= h_sync_start) && (h_nxt < h_sync_end);
      vga_out.vsync  <= (v_nxt >= v_sync_start) && (v_nxt < v_sync_end);
      vga_out.hblnk  <= (h_nxt >= h_visible);
      vga_out.vblnk  <= (v_nxt >= v_visible);
      vga_out.rgb    <= rgb_black;  // painted later
    end
  end

endmodule

//--- draw_background.sv
/*
 * draw_background
 * first drawing stage, white frame border and a colour ramp
 * taken from the pixel position, black while blanking
 */

`timescale 1ns/10ps

module draw_background import vga_pkg::*; (
  input  logic     pclk,
  input  logic     rst,
  input  vga_bus_t vga_in,
  output vga_bus_t vga_out
);

  logic [11:0] rgb_nxt;
  logic        on_border;

  assign on_border = (vga_in.hcount == 11'd0) || (vga_in.hcount == h_visible - 11'd1) ||
                     (vga_in.vcount == 11'd0) || (vga_in.vcount == v_visible - 11'd1);

  always_comb begin
    if (vga_in.hblnk || vga_in.vblnk) begin
      rgb_nxt = rgb_black;
    end else if (on_border) begin
      rgb_nxt = rgb_white;
    end else begin
      // red steps across, green steps down
      rgb_nxt = {vga_in.hcount[9:6], vga_in.vcount[8:5], 4'h8};
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out <= '0;
    end else begin
      vga_out     <= vga_in;
      vga_out.rgb <= rgb_nxt;
    end
  end

endmodule

//--- draw_rect_char.sv
/*
 * draw_rect_char
 * text window stage, issues cell and glyph line addresses and
 * paints glyph pixels over the picture, three cycles of latency
 */

`timescale 1ns/10ps

module draw_rect_char import vga_pkg::*; (
  input  logic        pclk,
  input  logic        rst,
  input  vga_bus_t    vga_in,
  input  logic [7:0]  char_pixels,
  input  logic [11:0] text_color,
  input  logic        text_enable,
  output logic [7:0]  char_xy,
  output logic [3:0]  char_line,
  output vga_bus_t    vga_out
);

  logic [10:0] x_rel;
  logic [10:0] y_rel;
  logic        in_win;
  logic [2:0]  col_d;    // column inside cell, aligned with char_pixels
  logic        in_win_d;
  vga_bus_t    vga_d;
  vga_bus_t    out_nxt;

  // position relative to window origin
  assign x_rel = vga_in.hcount - rect_x;
  assign y_rel = vga_in.vcount - rect_y;

  assign in_win = (vga_in.hcount >= rect_x) && (vga_in.hcount < rect_x + rect_w) &&
                  (vga_in.vcount >= rect_y) && (vga_in.vcount < rect_y + rect_h);

  assign char_xy = {y_rel[7:4], x_rel[6:3]};  // row, column

  // line goes out with char_code, one cycle after char_xy
  always_ff @(posedge pclk) begin
    if (rst) begin
      char_line <= 4'd0;
    end else begin
      char_line <= y_rel[3:0];
    end
  end

  // two cycles cover the code lookup and the font lookup
  delay #(.width($bits(vga_bus_t)), .clk_del(2)) u_bus_delay (
    .clk  (pclk),
    .rst  (rst),
    .din  (vga_in),
    .dout (vga_d)
  );

  delay #(.width(4), .clk_del(2)) u_pos_delay (
    .clk  (pclk),
    .rst  (rst),
    .din  ({in_win, x_rel[2:0]}),
    .dout ({in_win_d, col_d})
  );

  always_comb begin
    out_nxt = vga_d;
    if (text_enable && !vga_d.hblnk && !vga_d.vblnk && in_win_d) begin
      // leftmost pixel of a cell is glyph bit 7
      if (char_pixels[char_w - 1 - col_d]) begin
        out_nxt.rgb = text_color;
      end else begin
        out_nxt.rgb = rgb_black;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out <= '0;
    end else begin
      vga_out <= out_nxt;
    end
  end

endmodule

//--- apb_text_regs.sv
/*
 * apb_text_regs
 * apb slave with the 256 character codes and the control word,
 * zero wait state, plus a registered read port for the video side
 */

`timescale 1ns/10ps

module apb_text_regs import vga_pkg::*; (
  input  logic        pclk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic [7:0]  char_xy,
  output logic [7:0]  char_code,
  output logic [11:0] text_color,
  output logic        text_enable
);

  localparam int n_cells = text_cols * text_rows;

  logic [7:0] cells [n_cells];
  apb_reg_e   reg_sel;
  logic       addr_err;
  logic [7:0] cell_idx;
  logic       wr_en;

  // unaligned or past ctrl is an error
  assign addr_err = (paddr[1:0] != 2'b00) || (paddr > ctrl_addr);
  assign reg_sel  = (paddr == ctrl_addr) ? ctrl : text_cells;
  assign cell_idx = paddr[9:2];
  assign wr_en    = psel && penable && pwrite && !addr_err;

  assign pready  = 1'b1;  // every access completes at once
  assign pslverr = psel && penable && addr_err;

  always_comb begin
    prdata = 32'd0;
    if (!addr_err) begin
      case (reg_sel)
        text_cells: prdata = {24'd0, cells[cell_idx]};
        ctrl:       prdata = {19'd0, text_enable, text_color};
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      for (int i = 0; i < n_cells; i++) cells[i] <= 8'd0;
      text_color  <= text_color_rst;
      text_enable <= 1'b1;
    end else if (wr_en) begin
      if (reg_sel == ctrl) begin
        text_color  <= pwdata[11:0];
        text_enable <= pwdata[12];
      end else begin
        cells[cell_idx] <= pwdata[7:0];
      end
    end
  end

  // video read port
  always_ff @(posedge pclk) begin
    if (rst) begin
      char_code <= 8'd0;
    end else begin
      char_code <= cells[char_xy];
    end
  end

endmodule

//--- font_rom.sv
/*
 * font_rom
 * 16 glyphs of 8x16 pixels, one byte per glyph line,
 * registered output one cycle after the address
 */

`timescale 1ns/10ps

module font_rom import vga_pkg::*; (
  input  logic       pclk,
  input  logic [7:0] char_code,
  input  logic [3:0] char_line,
  output logic [7:0] char_pixels
);

  logic [7:0] rom [16 * char_h];

  initial begin
    $readmemh("font_rom.mem", rom);
  end

  // only the low nibble of the code picks a glyph
  always_ff @(posedge pclk) begin
    char_pixels <= rom[{char_code[3:0], char_line}];
  end

endmodule

//--- vga_text_top.sv
/*
 * vga_text_top
 * text overlay pipeline, timing -> background -> character box,
 * with the apb register block and the font memory on the side
 */

`timescale 1ns/10ps

module vga_text_top import vga_pkg::*; (
  input  logic        pclk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        hsync,
  output logic        vsync,
  output logic [11:0] rgb
);

  vga_bus_t    vga_tim;
  vga_bus_t    vga_bg;
  vga_bus_t    vga_txt;
  logic [7:0]  char_xy;
  logic [3:0]  char_line;
  logic [7:0]  char_code;
  logic [7:0]  char_pixels;
  logic [11:0] text_color;
  logic        text_enable;

  vga_timing u_vga_timing (
    .pclk    (pclk),
    .rst     (rst),
    .vga_out (vga_tim)
  );

  draw_background u_draw_background (
    .pclk    (pclk),
    .rst     (rst),
    .vga_in  (vga_tim),
    .vga_out (vga_bg)
  );

  draw_rect_char u_draw_rect_char (
    .pclk        (pclk),
    .rst         (rst),
    .vga_in      (vga_bg),
    .char_pixels (char_pixels),
    .text_color  (text_color),
    .text_enable (text_enable),
    .char_xy     (char_xy),
    .char_line   (char_line),
    .vga_out     (vga_txt)
  );

  apb_text_regs u_apb_text_regs (
    .pclk        (pclk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .char_xy     (char_xy),
    .char_code   (char_code),
    .text_color  (text_color),
    .text_enable (text_enable)
  );

  font_rom u_font_rom (
    .pclk        (pclk),
    .char_code   (char_code),
    .char_line   (char_line),
    .char_pixels (char_pixels)
  );

  assign hsync = vga_txt.hsync;
  assign vsync = vga_txt.vsync;
  assign rgb   = vga_txt.rgb;

endmodule

//--- tb_vga_text.sv
/*
 * tb_vga_text
 * testbench for the text overlay, apb driver, a pixel model that
 * locates pixels from the sync edges, frame by frame rgb checks
 */

`timescale 1ns/10ps

module tb_vga_text import vga_pkg::*; ();

  localparam int frame_ns   = 800 * 525 * 40;
  localparam int apb_ns     = 540 * 3 * 40;          // all transfers, 3 cycles each
  localparam int timeout_ns = 5 * frame_ns + apb_ns; // four frame waits plus margin

  logic        pclk = 1'b0;
  logic        rst;
  logic        psel, penable, pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr, hsync, vsync;
  logic [11:0] rgb;

  logic [7:0]  cell_ref [256];
  logic [7:0]  font_ref [256];
  logic [11:0] color_ref;
  logic        enable_ref;
  logic [31:0] lfsr;
  int errors = 0;
  int sync_errs = 0;
  int ntests = 0;
  int nfail = 0;
  int vs_periods = 0;

  // pixel tracker state
  int px, py, hs_len, hs_period, vs_lines, vs_high;
  logic prev_hs, prev_vs, hs_seen, vs_seen;

  vga_text_top i_dut (
    .pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .hsync(hsync), .vsync(vsync), .rgb(rgb)
  );

  always #20 pclk = ~pclk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] b;
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  // picture expected at screen position x, y
  function automatic logic [11:0] expected_rgb(input int x, input int y);
    int cx;
    int cy;
    logic [7:0]  code;
    logic [7:0]  glyph;
    logic [11:0] bg;
    if (x >= 640 || y >= 480) return 12'h000;
    if (x == 0 || x == 639 || y == 0 || y == 479) bg = 12'hfff;
    else bg = {4'(x >> 6), 4'(y >> 5), 4'h8};
    cx = x - 250;
    cy = y - 200;
    if (!enable_ref || cx < 0 || cx >= 128 || cy < 0 || cy >= 256) return bg;
    code  = cell_ref[(cy / 16) * 16 + cx / 8];
    glyph = font_ref[code[3:0] * 16 + cy % 16];
    return glyph[7 - cx % 8] ? color_ref : 12'h000;  // leftmost column is bit 7
  endfunction

  task automatic fail_msg(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic sync_fail(input string msg);
    sync_errs++;
    fail_msg(msg);
  endtask

  task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge pclk);
    #2;
    psel    = 1'b1;  // setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge pclk);
    #2;
    penable = 1'b1;
    #20;
    assert (pready) else fail_msg($sformatf("pready low in access to %h", addr));
    rdata = prdata;  // zero wait, access ends at the next edge
    err   = pslverr;
    @(posedge pclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_transfer(1'b1, addr, data, rd, err);
    assert (err == exp_err)
      else fail_msg($sformatf("pslverr %0b on write to %h, expected %0b", err, addr, exp_err));
    if (!exp_err && addr == 12'h400) begin
      color_ref  = data[11:0];
      enable_ref = data[12];
    end else if (!exp_err) begin
      cell_ref[addr[9:2]] = data[7:0];
    end
  endtask

  task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp, input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_transfer(1'b0, addr, 32'h0, rd, err);
    assert (err == exp_err)
      else fail_msg($sformatf("pslverr %0b on read of %h, expected %0b", err, addr, exp_err));
    if (!exp_err) begin
      assert (rd == exp) else fail_msg($sformatf("read %h from %h, expected %h", rd, addr, exp));
    end
  endtask

  task automatic report_test(input string name, input int base);
    ntests++;
    if (errors == base) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - base);
      nfail++;
    end
  endtask

  // pixel position from sync edges, sync timing and rgb checks
  always @(posedge pclk) begin
    if (rst) begin
      {prev_hs, prev_vs, hs_seen, vs_seen} = '0;
      {px, py, hs_len, hs_period, vs_lines, vs_high} = '0;
    end else begin
      hs_period++;
      if (hsync) hs_len++;
      px = (px + 1) % 800;
      if (px == 0) py = (py + 1) % 525;
      if (hsync && !prev_hs) begin
        if (hs_seen) begin
          assert (hs_period == 800) else sync_fail($sformatf("hsync period %0d", hs_period));
        end
        hs_seen   = 1'b1;
        hs_period = 0;
        px        = 656;
        vs_lines++;
        if (vsync) vs_high++;
      end
      if (!hsync && prev_hs) begin
        assert (hs_len == 96) else sync_fail($sformatf("hsync width %0d", hs_len));
        hs_len = 0;
      end
      if (vsync && !prev_vs) begin
        if (vs_seen) begin
          vs_periods++;
          assert (vs_lines == 525)
            else sync_fail($sformatf("vsync period %0d lines", vs_lines));
        end
        vs_seen  = 1'b1;
        vs_lines = 0;
        vs_high  = 0;
        py       = 490;
      end
      if (!vsync && prev_vs) begin
        assert (vs_high == 2) else sync_fail($sformatf("vsync width %0d lines", vs_high));
      end
      if (hs_seen && vs_seen) begin
        assert (rgb == expected_rgb(px, py))
          else fail_msg($sformatf("rgb %h at x %0d y %0d, expected %h",
                                  rgb, px, py, expected_rgb(px, py)));
      end
      prev_hs = hsync;
      prev_vs = vsync;
    end
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("Test failures found");
    $finish;
  end

  initial begin
    int base;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 12'h000;
    pwdata = 32'h0;
    lfsr = 32'hfd78;
    color_ref = 12'h8f8;
    enable_ref = 1'b1;
    for (int n = 0; n < 256; n++) cell_ref[n] = 8'h00;
    $readmemh("font_rom.mem", font_ref);
    repeat (2) @(posedge pclk);
    #2;
    rst = 1'b0;

    base = errors;
    apb_read(12'h000, 32'h0, 1'b0);
    apb_read(12'h3fc, 32'h0, 1'b0);
    apb_read(ctrl_addr, 32'h0000_18f8, 1'b0);  // enable set, default colour
    report_test("reset values", base);

    @(posedge vsync);  // window is far away, safe to fill
    base = errors;
    for (int n = 0; n < 256; n++) apb_write(12'(4 * n), {24'h0, random_byte()}, 1'b0);
    for (int n = 0; n < 256; n++) apb_read(12'(4 * n), {24'h0, cell_ref[n]}, 1'b0);
    apb_read(ctrl_addr, 32'h0000_18f8, 1'b0);
    report_test("register readback", base);

    base = errors;
    apb_write(12'h404, {24'h0, ~cell_ref[1]}, 1'b1);
    apb_write(12'h7fc, {24'h0, ~cell_ref[255]}, 1'b1);
    apb_write(12'h006, {24'h0, ~cell_ref[1]}, 1'b1);  // unaligned
    apb_read(12'h404, 32'h0, 1'b1);
    apb_read(ctrl_addr, 32'h0000_18f8, 1'b0);
    apb_read(12'h004, {24'h0, cell_ref[1]}, 1'b0);
    apb_read(12'h3fc, {24'h0, cell_ref[255]}, 1'b0);
    report_test("error response", base);

    base = errors;
    @(posedge vsync);
    report_test("text rendering", base);

    base = errors;
    apb_write(ctrl_addr, 32'h0000_10f3, 1'b0);
    apb_read(ctrl_addr, 32'h0000_10f3, 1'b0);
    @(posedge vsync);
    report_test("colour change", base);

    base = errors;
    apb_write(ctrl_addr, 32'h0000_00f3, 1'b0);
    @(posedge vsync);
    report_test("background with text disabled", base);

    ntests++;
    if (sync_errs == 0 && vs_periods > 0) begin
      $display("test sync timing: ok, %0d frames measured", vs_periods);
    end else begin
      if (vs_periods == 0) errors++;
      $display("test sync timing: failed, %0d errors, %0d frames measured",
               sync_errs, vs_periods);
      nfail++;
    end

    $display("%0d tests run, %0d failed, %0d errors", ntests, nfail, errors);
    if (errors == 0 && nfail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- font_rom.mem
// glyphs for the hex digits 0..9 and a..f, one glyph per line, code 0 first
// 16 bytes per line = glyph rows 0..15 top to bottom, bit 7 is the leftmost pixel
00 00 7c c6 c6 ce de f6 e6 c6 c6 7c 00 00 00 00
00 00 18 38 78 18 18 18 18 18 18 7e 00 00 00 00
00 00 7c c6 06 0c 18 30 60 c0 c6 fe 00 00 00 00
00 00 7c c6 06 06 3c 06 06 06 c6 7c 00 00 00 00
00 00 0c 1c 3c 6c cc fe 0c 0c 0c 1e 00 00 00 00
00 00 fe c0 c0 c0 fc 06 06 06 c6 7c 00 00 00 00
00 00 38 60 c0 c0 fc c6 c6 c6 c6 7c 00 00 00 00
00 00 fe c6 06 06 0c 18 30 30 30 30 00 00 00 00
00 00 7c c6 c6 c6 7c c6 c6 c6 c6 7c 00 00 00 00
00 00 7c c6 c6 c6 7e 06 06 06 0c 78 00 00 00 00
00 00 10 38 6c c6 c6 fe c6 c6 c6 c6 00 00 00 00
00 00 fc 66 66 66 7c 66 66 66 66 fc 00 00 00 00
00 00 3c 66 c2 c0 c0 c0 c0 c2 66 3c 00 00 00 00
00 00 f8 6c 66 66 66 66 66 66 6c f8 00 00 00 00
00 00 fe 66 62 68 78 68 60 62 66 fe 00 00 00 00
00 00 fe 66 62 68 78 68 60 60 60 f0 00 00 00 00

//--- vga_text.f
vga_pkg.sv
delay.sv
vga_timing.sv
draw_background.sv
draw_rect_char.sv
apb_text_regs.sv
font_rom.sv
vga_text_top.sv
tb_vga_text.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vga text overlay testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_vga_text \
  -f vga_text.f -o sim_vga_text \
  && ./obj_dir/sim_vga_text | tee sim.log \
  || { echo "build or simulation did not run"; exit 1; }

grep -q 'All tests passed!' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
